//--- axil_slave.sv
`timescale 1ns/100ps
`default_nettype none

module axil_slave (
   input  wire                                    clk,
   input  wire                                    reset_n,
   // write address
   input  wire  [board_io_pkg::axil_addr_w-1:0]   awaddr,
   input  wire                                    awvalid,
   output logic                                   awready,
   // write data
   input  wire  [board_io_pkg::axil_data_w-1:0]   wdata,
   input  wire  [3:0]                             wstrb,
   input  wire                                    wvalid,
   output logic                                   wready,
   // write response
   output logic [1:0]                             bresp,
   output logic                                   bvalid,
   input  wire                                    bready,
   // read address
   input  wire  [board_io_pkg::axil_addr_w-1:0]   araddr,
   input  wire                                    arvalid,
   output logic                                   arready,
   // read data
   output logic [board_io_pkg::axil_data_w-1:0]   rdata,
   output logic [1:0]                             rresp,
   output logic                                   rvalid,
   input  wire                                    rready,
   reg_bus_if.master                              bus
);

   import board_io_pkg::*;

   bus_state_e state;
   logic       wr_pending;
   logic       wr_accept;
   logic       rd_accept;

   assign wr_pending = awvalid || wvalid;
   assign wr_accept  = (state == st_idle) && awvalid && wvalid;
   assign rd_accept  = arready && arvalid;

   assign awready = wr_accept;   // both channels taken in one cycle
   assign wready  = wr_accept;
   assign arready = (state == st_idle) && !wr_pending;   // writes first

   assign bus.wr_en   = wr_accept && wstrb[0];
   assign bus.rd_en   = rd_accept;
   assign bus.addr    = wr_accept ? reg_addr_e'(awaddr[3:2]) : reg_addr_e'(araddr[3:2]);
   assign bus.wr_data = wdata[reg_w-1:0];

   assign rresp = resp_okay;   // every register is readable

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state  <= st_idle;
         bvalid <= 1'b0;
         rvalid <= 1'b0;
         bresp  <= resp_okay;
      end else begin
         case (state)
            st_idle: begin
               if (wr_accept) begin
                  state  <= st_write_resp;
                  bvalid <= 1'b1;
                  bresp  <= bus.addr_err ? resp_slverr : resp_okay;
               end else if (rd_accept) begin
                  state <= st_read_resp;   // rd_data lands next cycle
               end
            end
            st_write_resp: begin
               if (bready) begin
                  bvalid <= 1'b0;
                  state  <= st_idle;
               end
            end
            st_read_resp: begin
               if (!rvalid) begin
                  rvalid <= 1'b1;
               end else if (rready) begin
                  rvalid <= 1'b0;
                  state  <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // captured once, then held while rvalid waits for rready
   always_ff @(posedge clk) begin
      if (state == st_read_resp && !rvalid) begin
         rdata <= axil_data_w'(bus.rd_data);
      end
   end

endmodule

`default_nettype wire

//--- board_io_pkg.sv
`default_nettype none

package board_io_pkg;

   localparam int axil_addr_w = 4;       // four word registers
   localparam int axil_data_w = 32;
   localparam int reg_w       = 8;       // registers live in the low byte
   localparam int num_digits  = 3;

   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   // register index, address bits 3..2
   typedef enum logic [1:0] {
      reg_buttons = 2'd0,
      reg_events  = 2'd1,
      reg_disp_lo = 2'd2,
      reg_disp_hi = 2'd3
   } reg_addr_e;

   typedef enum logic [1:0] {
      st_idle,
      st_write_resp,
      st_read_resp
   } bus_state_e;

   // segment order is p g f e d c b a, active low, dp off
   function automatic logic [7:0] hex_to_seg(input logic [3:0] value);
      case (value)
         4'h0: return 8'b1100_0000;
         4'h1: return 8'b1111_1001;
         4'h2: return 8'b1010_0100;
         4'h3: return 8'b1011_0000;
         4'h4: return 8'b1001_1001;
         4'h5: return 8'b1001_0010;
         4'h6: return 8'b1000_0010;
         4'h7: return 8'b1111_1000;
         4'h8: return 8'b1000_0000;
         4'h9: return 8'b1001_0000;
         4'ha: return 8'b1000_1000;
         4'hb: return 8'b1000_0011;
         4'hc: return 8'b1100_0110;
         4'hd: return 8'b1010_0001;
         4'he: return 8'b1000_0110;
         default: return 8'b1000_1110;   // f
      endcase
   endfunction

endpackage

`default_nettype wire

//--- board_io_props.sv
`timescale 1ns/100ps
`default_nettype none

module board_io_props (
   input wire         clk,
   input wire         reset_n,
   input wire         awready,
   input wire         arready,
   input wire  [1:0]  bresp,
   input wire         bvalid,
   input wire         bready,
   input wire  [31:0] rdata,
   input wire         rvalid,
   input wire         rready,
   input wire  [2:0]  lcd_digit
);

   a_bvalid_held: assert property (@(posedge clk) disable iff (!reset_n)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else $error("bvalid dropped or bresp changed before bready");

   a_rvalid_held: assert property (@(posedge clk) disable iff (!reset_n)
      rvalid && !rready |=> rvalid && $stable(rdata))
      else $error("rvalid dropped or rdata changed before rready");

   // one select at most, stepping 100 -> 010 -> 001
   a_digit_order: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0(lcd_digit) && ($stable(lcd_digit) || $past(lcd_digit) == 3'b000
         || lcd_digit == $past({lcd_digit[0], lcd_digit[2:1]})))
      else $error("lcd_digit not one-hot or out of scan order");

   a_accept_idle: assert property (@(posedge clk) disable iff (!reset_n)
      (awready || arready) |-> !(awready && arready) && !bvalid && !rvalid)
      else $error("two accepts at once, or an accept while a response waits");

endmodule

bind board_io_top board_io_props u_props (.*);

`default_nettype wire

//--- board_io_top.sv
`timescale 1ns/100ps
`default_nettype none

module board_io_top #(
   parameter int num_buttons      = 5,
   parameter int sample_div       = 100000,   // 2 ms at 50 MHz
   parameter int debounce_samples = 4,
   parameter int scan_div         = 50000
) (
   input  wire                                    clk,
   input  wire                                    reset_n,
   input  wire  [board_io_pkg::axil_addr_w-1:0]   awaddr,
   input  wire                                    awvalid,
   output logic                                   awready,
   input  wire  [board_io_pkg::axil_data_w-1:0]   wdata,
   input  wire  [3:0]                             wstrb,
   input  wire                                    wvalid,
   output logic                                   wready,
   output logic [1:0]                             bresp,
   output logic                                   bvalid,
   input  wire                                    bready,
   input  wire  [board_io_pkg::axil_addr_w-1:0]   araddr,
   input  wire                                    arvalid,
   output logic                                   arready,
   output logic [board_io_pkg::axil_data_w-1:0]   rdata,
   output logic [1:0]                             rresp,
   output logic                                   rvalid,
   input  wire                                    rready,
   input  wire  [num_buttons-1:0]                 buttons,
   output logic [7:0]                             lcd_segment,
   output logic [board_io_pkg::num_digits-1:0]    lcd_digit
);

   import board_io_pkg::*;

   logic [num_buttons-1:0]  sync_level;
   logic                    sample_tick;
   logic [num_buttons-1:0]  stable;
   logic [4*num_digits-1:0] disp_value;
   logic [num_digits-1:0]   blank;

   reg_bus_if rbus ();

   axil_slave u_axil (
      .clk, .reset_n,
      .awaddr, .awvalid, .awready,
      .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready,
      .rdata, .rresp, .rvalid, .rready,
      .bus (rbus.master)
   );

   button_sampler #(.num_buttons(num_buttons), .sample_div(sample_div)) u_sampler (
      .clk, .reset_n, .buttons, .level(sync_level), .sample_tick
   );

   for (genvar i = 0; i < num_buttons; i++) begin : g_key
      key_debounce #(.debounce_samples(debounce_samples)) u_key (
         .clk, .reset_n, .raw(sync_level[i]), .sample_tick, .stable(stable[i])
      );
   end

   io_regs #(.num_buttons(num_buttons)) u_regs (
      .clk, .reset_n, .bus(rbus.slave), .stable, .disp_value, .blank
   );

   seg_display #(.scan_div(scan_div)) u_display (
      .clk, .reset_n, .disp_value, .blank, .lcd_segment, .lcd_digit
   );

endmodule

`default_nettype wire

//--- button_sampler.sv
`timescale 1ns/100ps
`default_nettype none

module button_sampler #(
   parameter int num_buttons = 5,
   parameter int sample_div  = 100000
) (
   input  wire                     clk,
   input  wire                     reset_n,
   input  wire  [num_buttons-1:0]  buttons,      // active low pins
   output logic [num_buttons-1:0]  level,        // active high
   output logic                    sample_tick
);

   localparam int cnt_w = $clog2(sample_div + 1);

   logic [num_buttons-1:0] sync_q;
   logic [cnt_w-1:0]       tick_cnt;

   // two flops, inverted on the way in
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         sync_q <= '0;
         level  <= '0;
      end else begin
         sync_q <= ~buttons;
         level  <= sync_q;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         tick_cnt    <= cnt_w'(sample_div - 1);
         sample_tick <= 1'b0;
      end else begin
         sample_tick <= (tick_cnt == '0);
         tick_cnt    <= (tick_cnt == '0) ? cnt_w'(sample_div - 1) : tick_cnt - 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- files.f
board_io_pkg.sv
reg_bus_if.sv
axil_slave.sv
button_sampler.sv
key_debounce.sv
io_regs.sv
seg_display.sv
board_io_top.sv
board_io_props.sv
tb_board_io.sv

//--- io_regs.sv
`timescale 1ns/100ps
`default_nettype none

module io_regs #(
   parameter int num_buttons = 5
) (
   input  wire                                        clk,
   input  wire                                        reset_n,
   reg_bus_if.slave                                   bus,
   input  wire  [num_buttons-1:0]                     stable,
   output logic [4*board_io_pkg::num_digits-1:0]      disp_value,
   output logic [board_io_pkg::num_digits-1:0]        blank
);

   import board_io_pkg::*;

   logic [num_buttons-1:0] stable_q;
   logic [num_buttons-1:0] events;
   logic [num_buttons-1:0] rise;
   logic [num_buttons-1:0] clr;

   assign rise = stable & ~stable_q;
   assign clr  = (bus.wr_en && bus.addr == reg_events) ? bus.wr_data[num_buttons-1:0] : '0;

   // levels are read-only
   assign bus.addr_err = (bus.addr == reg_buttons);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         stable_q <= '0;
         events   <= '0;
      end else begin
         stable_q <= stable;
         events   <= (events & ~clr) | rise;   // a new press beats the clear
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         disp_value <= 12'hdef;
         blank      <= '0;
      end else if (bus.wr_en) begin
         case (bus.addr)
            reg_disp_lo: begin
               disp_value[7:0] <= bus.wr_data;
            end
            reg_disp_hi: begin
               blank            <= bus.wr_data[6:4];
               disp_value[11:8] <= bus.wr_data[3:0];
            end
            default: ;   // buttons read-only, events handled above
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (bus.rd_en) begin
         case (bus.addr)
            reg_buttons: bus.rd_data <= reg_w'(stable);
            reg_events:  bus.rd_data <= reg_w'(events);
            reg_disp_lo: bus.rd_data <= disp_value[7:0];
            reg_disp_hi: bus.rd_data <= {1'b0, blank, disp_value[11:8]};
            default:     bus.rd_data <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- key_debounce.sv
`timescale 1ns/100ps
`default_nettype none

module key_debounce #(
   parameter int debounce_samples = 4
) (
   input  wire   clk,
   input  wire   reset_n,
   input  wire   raw,
   input  wire   sample_tick,
   output logic  stable
);

   localparam int cnt_w = $clog2(debounce_samples + 1);

   logic [cnt_w-1:0] run_cnt;
   logic [cnt_w-1:0] run_next;

   assign run_next = run_cnt + 1'b1;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         run_cnt <= '0;
         stable  <= 1'b0;
      end else if (sample_tick) begin
         if (raw == stable) begin
            run_cnt <= '0;   // glitch, start over
         end else if (run_next == cnt_w'(debounce_samples)) begin
            stable  <= raw;
            run_cnt <= '0;
         end else begin
            run_cnt <= run_next;
         end
      end
   end

endmodule

`default_nettype wire

//--- reg_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

// single-cycle register strobes from the AXI slave to the register block
interface reg_bus_if;

   logic                            wr_en;
   logic                            rd_en;
   board_io_pkg::reg_addr_e         addr;
   logic [board_io_pkg::reg_w-1:0]  wr_data;
   logic [board_io_pkg::reg_w-1:0]  rd_data;    // valid the cycle after rd_en
   logic                            addr_err;   // sampled with wr_en

   modport master (
      output wr_en, rd_en, addr, wr_data,
      input  rd_data, addr_err
   );

   modport slave (
      input  wr_en, rd_en, addr, wr_data,
      output rd_data, addr_err
   );

endinterface

`default_nettype wire

//--- seg_display.sv
`timescale 1ns/100ps
`default_nettype none

module seg_display #(
   parameter int scan_div = 50000
) (
   input  wire                                        clk,
   input  wire                                        reset_n,
   input  wire  [4*board_io_pkg::num_digits-1:0]      disp_value,
   input  wire  [board_io_pkg::num_digits-1:0]        blank,
   output logic [7:0]                                 lcd_segment,
   output logic [board_io_pkg::num_digits-1:0]        lcd_digit
);

   import board_io_pkg::*;

   localparam int cnt_w = $clog2(scan_div + 1);

   logic [cnt_w-1:0]      scan_cnt;
   logic [1:0]            digit_idx;   // digit shown at the next step
   logic                  step;
   logic [3:0]            nibble;
   logic [7:0]            next_seg;
   logic [num_digits-1:0] next_sel;

   assign step   = (scan_cnt == '0);
   assign nibble = disp_value[digit_idx*4 +: 4];

   always_comb begin
      next_seg = blank[digit_idx] ? 8'hff : hex_to_seg(nibble);
      next_sel = '0;
      next_sel[num_digits-1-digit_idx] = 1'b1;   // digit 0 is the msb
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         scan_cnt <= cnt_w'(scan_div - 1);
      end else begin
         scan_cnt <= step ? cnt_w'(scan_div - 1) : scan_cnt - 1'b1;
      end
   end

   // select and segments move together
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         digit_idx   <= '0;
         lcd_digit   <= '0;
         lcd_segment <= 8'hff;
      end else if (step) begin
         lcd_digit   <= next_sel;
         lcd_segment <= next_seg;
         if (digit_idx == 2'(num_digits - 1)) begin
            digit_idx <= '0;
         end else begin
            digit_idx <= digit_idx + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- tb_board_io.sv
`timescale 1ns/100ps
`default_nettype none

module tb_board_io;

   import board_io_pkg::*;

   localparam int scan_div      = 8;
   localparam int settle_cycles = 40;   // worst button latency is about 19
   localparam int view_cycles   = 80;
   localparam int txn_cycles    = 20;
   localparam int test_cycles   = 10 + 60 * txn_cycles + 3 * settle_cycles
                                  + 2 * (view_cycles + 3 * scan_div);

   // lit segments g..a per hex digit, f down to 0
   localparam logic [16*7-1:0] lit_segs = {
      7'h71, 7'h79, 7'h5e, 7'h39, 7'h7c, 7'h77, 7'h6f, 7'h7f,
      7'h07, 7'h7d, 7'h6d, 7'h66, 7'h4f, 7'h5b, 7'h06, 7'h3f
   };

   logic        clk = 1'b0;
   logic        reset_n = 1'b0;
   logic [3:0]  awaddr = '0, araddr = '0, wstrb = '0;
   logic [31:0] wdata = '0;
   logic        awvalid = 1'b0, wvalid = 1'b0, bready = 1'b0, arvalid = 1'b0, rready = 1'b0;
   logic [4:0]  buttons = 5'h1f;   // active low, all released
   logic        awready, wready, bvalid, arready, rvalid;
   logic [1:0]  bresp, rresp;
   logic [31:0] rdata;
   logic [7:0]  lcd_segment;
   logic [2:0]  lcd_digit;

   integer      seed = 32'h9582_4cdc;
   int          n_errors = 0, n_checks = 0, n_tests = 0, n_digits = 0, run_len = 0;
   logic        long_hold = 1'b0;
   logic        disp_check = 1'b0;
   logic [1:0]  rd_idx = '0;
   logic [2:0]  prev_digit = '0;
   logic [7:0]  exp_lo = 8'hef;
   logic [7:0]  exp_hi = 8'h0d;
   logic [4:0]  exp_levels = '0;
   logic [4:0]  exp_events = '0;

   board_io_top #(.sample_div(4), .debounce_samples(3), .scan_div(scan_div)) u_dut (.*);

   initial forever #2 clk = ~clk;

   function automatic logic [7:0] expected_reg(input logic [1:0] idx);
      case (idx)
         2'd0:    return {3'b000, exp_levels};
         2'd1:    return {3'b000, exp_events};
         2'd2:    return exp_lo;
         default: return {1'b0, exp_hi[6:0]};   // bit 7 not stored
      endcase
   endfunction

   function automatic logic [7:0] expected_seg(input logic [2:0] sel);
      logic [1:0] idx;
      logic [3:0] nib;
      idx = sel[2] ? 2'd0 : (sel[1] ? 2'd1 : 2'd2);   // digit 0 is 100
      nib = (idx == 2'd0) ? exp_lo[3:0] : (idx == 2'd1) ? exp_lo[7:4] : exp_hi[3:0];
      return exp_hi[4 + idx] ? 8'hff : {1'b1, ~lit_segs[nib*7 +: 7]};
   endfunction

   task automatic report_mismatch(input string what);
      n_errors++;
      $display("ERR %0t: %s", $time, what);
   endtask

   task automatic end_test(input string name, input int mark);
      n_tests++;
      $display("%s: %s, %0d errors", name, (n_errors == mark) ? "ok" : "failed", n_errors - mark);
   endtask

   task automatic axi_write(input logic [3:0] addr, input logic [7:0] data,
                            input logic [1:0] exp_resp);
      int          hold;
      int          i;
      logic [1:0]  first_resp;
      logic [31:0] noise;
      noise = $random(seed);
      awaddr  <= addr;
      wdata   <= {noise[31:8], data};   // upper bits must be ignored
      wstrb   <= 4'hf;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      do @(posedge clk); while (!(awready && wready));
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      hold = long_hold ? 3 + $unsigned($random(seed)) % 8 : $unsigned($random(seed)) % 3;
      arvalid <= long_hold;   // read offered while the response waits
      araddr  <= 4'h8;
      for (i = 0; i < hold; i++) begin
         @(posedge clk);
         if (i == 0) begin
            first_resp = bresp;
         end
         n_checks++;
         if (!bvalid || bresp !== first_resp || arready) begin
            report_mismatch("write response not held, or a read accepted meanwhile");
         end
      end
      bready <= 1'b1;
      do @(posedge clk); while (!bvalid);
      bready  <= 1'b0;
      arvalid <= 1'b0;
      n_checks++;
      if (bresp !== exp_resp) begin
         report_mismatch($sformatf("write to %h gave bresp %0d, expected %0d",
                                   addr, bresp, exp_resp));
      end
   endtask

   task automatic axi_read(input logic [1:0] idx);
      int          hold;
      int          i;
      logic        seen;
      logic [31:0] first_data;
      seen = 1'b0;
      rd_idx  <= idx;
      araddr  <= {idx, 2'b00};
      arvalid <= 1'b1;
      do @(posedge clk); while (!arready);
      arvalid <= 1'b0;
      hold = long_hold ? 3 + $unsigned($random(seed)) % 8 : $unsigned($random(seed)) % 3;
      for (i = 0; i < hold; i++) begin
         @(posedge clk);
         n_checks++;
         if (arready || (seen && (!rvalid || rdata !== first_data))) begin
            report_mismatch("read response not held, or a new read accepted");
         end
         if (!seen && rvalid) begin
            first_data = rdata;
            seen = 1'b1;
         end
      end
      rready <= 1'b1;
      do @(posedge clk); while (!rvalid);
      rready <= 1'b0;
   endtask

   task automatic set_buttons(input logic [4:0] pressed, input int cycles);
      buttons <= ~pressed;
      repeat (cycles) @(posedge clk);
   endtask

   task automatic scan_view(input logic [7:0] lo, input logic [7:0] hi);
      int start;
      axi_write(4'h8, lo, resp_okay);
      exp_lo = lo;
      axi_write(4'hc, hi, resp_okay);
      exp_hi = hi;
      repeat (3 * scan_div + 1) @(posedge clk);   // every digit refreshed
      start = n_digits;
      disp_check <= 1'b1;
      repeat (view_cycles) @(posedge clk);
      disp_check <= 1'b0;
      if (n_digits - start < view_cycles / scan_div - 2) begin
         n_errors++;
         $display("display scan stalled, only %0d digit changes seen", n_digits - start);
      end
   endtask

   // compares read data and display steps against the reference
   always @(posedge clk) begin
      if (rvalid && rready) begin
         n_checks++;
         if (rdata !== {24'h0, expected_reg(rd_idx)} || rresp !== resp_okay) begin
            report_mismatch($sformatf("reg %0d read %h resp %0d, expected %h", rd_idx,
                                      rdata, rresp, expected_reg(rd_idx)));
         end
      end
      if (lcd_digit !== prev_digit) begin
         if (disp_check && prev_digit != 3'b000) begin
            n_checks++;
            n_digits++;
            if (lcd_digit !== {prev_digit[0], prev_digit[2:1]} || run_len != scan_div
                || lcd_segment !== expected_seg({prev_digit[0], prev_digit[2:1]})) begin
               report_mismatch($sformatf("digit %b seg %h after %0d cycles, expected seg %h",
                  lcd_digit, lcd_segment, run_len, expected_seg({prev_digit[0], prev_digit[2:1]})));
            end
         end
         prev_digit = lcd_digit;
         run_len = 1;
      end else begin
         run_len++;
      end
   end

   initial begin
      int          i;
      int          mark;
      logic [31:0] v;
      repeat (10) @(posedge clk);
      reset_n <= 1'b1;

      mark = n_errors;
      @(posedge clk);
      n_checks++;
      if (bvalid || rvalid || lcd_digit !== 3'b000) begin
         report_mismatch("bvalid, rvalid or lcd_digit not idle after reset");
      end
      axi_read(2'd0);
      axi_read(2'd2);
      end_test("reset state", mark);

      mark = n_errors;
      for (i = 0; i < 6; i++) begin
         v = $random(seed);
         axi_write(4'h8, v[7:0], resp_okay);
         exp_lo = v[7:0];
         axi_write(4'hc, v[15:8], resp_okay);
         exp_hi = v[15:8];
         axi_read(2'd2);
         axi_read(2'd3);
      end
      axi_write(4'h0, 8'h1f, resp_slverr);   // levels are read-only
      axi_read(2'd0);
      end_test("register access", mark);

      mark = n_errors;
      set_buttons(5'b00001, 3);   // tap shorter than one sample
      set_buttons(5'b00000, settle_cycles);
      axi_read(2'd0);
      axi_read(2'd1);
      set_buttons(5'b01010, settle_cycles);
      exp_levels = 5'b01010;
      exp_events = 5'b01010;
      axi_read(2'd0);
      axi_read(2'd1);
      set_buttons(5'b00000, settle_cycles);
      exp_levels = 5'b00000;
      axi_read(2'd0);
      axi_read(2'd1);
      end_test("debounce", mark);

      mark = n_errors;
      axi_write(4'h4, 8'h02, resp_okay);
      exp_events = 5'b01000;
      axi_read(2'd1);
      axi_write(4'h4, 8'h08, resp_okay);
      exp_events = 5'b00000;
      axi_read(2'd1);
      end_test("event clearing", mark);

      mark = n_errors;
      scan_view(8'h5a, 8'h23);   // digit 1 blanked
      scan_view(8'h19, 8'h50);
      end_test("display scan", mark);

      mark = n_errors;
      long_hold = 1'b1;
      for (i = 0; i < 4; i++) begin
         v = $random(seed);
         axi_write(4'h8, v[7:0], resp_okay);
         exp_lo = v[7:0];
         axi_read(2'd2);
         axi_read(2'd0);
      end
      long_hold = 1'b0;
      end_test("back-pressure", mark);

      $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(2 * test_cycles * 4);
      $display("watchdog: run did not finish within %0d cycles", 2 * test_cycles);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
